//--- tb/cpu_vectors.txt
# P addr op targ a_sel b_sel cond direct set_flags operand (hex), I input byte (hex)
# E test expected_output_byte (test decimal, byte hex)
P 000 02 0 7 6 0 0 0 005A
P 001 02 1 7 6 0 0 0 0013
P 002 00 6 0 1 0 0 0 0000
P 003 01 6 0 1 0 0 0 0000
P 004 02 6 0 1 0 0 0 0000
P 005 03 6 0 1 0 0 0 0000
P 006 04 6 0 1 0 0 0 0000
P 007 05 6 0 1 0 0 0 0000
P 008 06 6 0 1 0 0 0 0000
P 009 07 6 0 1 0 0 0 0000
P 00A 08 6 0 1 0 0 0 0000
P 00B 09 6 0 1 0 0 0 0000
P 00C 0A 6 0 1 0 0 0 0000
P 00D 0B 6 0 1 0 0 0 0000
P 00E 0C 6 0 1 0 0 0 0000
P 00F 0D 6 0 1 0 0 0 0000
P 010 0E 6 0 1 0 0 0 0000
P 011 0F 6 0 1 0 0 0 0000
P 012 03 F 0 6 0 0 1 00C0
P 013 02 6 0 6 1 0 0 0001
P 014 02 6 0 6 2 0 0 0002
P 015 02 6 0 6 6 0 0 0003
P 016 02 6 0 6 5 0 0 0004
P 017 03 F 0 6 2 0 1 0000
P 018 06 6 0 6 0 0 0 0001
P 019 02 2 7 6 0 0 0 0090
P 01A 03 F 2 6 0 0 1 0090
P 01B 02 6 0 6 3 0 0 0005
P 01C 06 6 2 6 0 0 0 0001
P 01D 01 7 0 0 0 1 0 0010
P 01E 02 4 0 6 0 0 0 0020
P 01F 01 7 2 0 0 0 0 0000
P 020 01 7 1 0 0 1 0 0101
P 021 02 6 0 7 0 1 0 0020
P 022 02 4 0 6 0 0 0 0010
P 023 02 6 0 7 0 0 0 0000
P 024 02 4 0 6 0 0 0 0001
P 025 02 5 0 6 0 0 0 0001
P 026 02 6 0 7 0 0 0 0000
P 027 03 3 3 6 0 0 0 0001
P 028 01 6 3 0 0 0 0 0000
P 029 04 F 3 6 0 0 1 0003
P 02A 02 9 0 6 6 0 0 0027
P 02B 02 8 0 6 0 0 0 0001
P 02C 02 A 0 6 0 0 0 0000
P 100 02 6 0 6 0 0 0 00AA
P 101 02 9 0 6 9 0 0 0003
P 102 02 9 0 6 0 0 0 0001
P 103 03 0 6 6 0 0 0 0001
P 104 02 9 0 6 A 0 0 0006
P 105 02 9 0 6 0 0 0 0004
P 106 01 6 0 0 0 0 0 0000
P 107 02 9 0 6 0 0 0 0001
I 10
I 7F
I FF
I 33
E 1 00
E 1 5A
E 1 13
E 1 6D
E 1 47
E 1 B9
E 1 6D
E 1 47
E 1 12
E 1 5B
E 1 49
E 1 A5
E 1 AE
E 1 06
E 1 B4
E 1 2D
E 2 01
E 2 03
E 2 5C
E 2 05
E 2 92
E 3 90
E 3 5A
E 3 13
E 4 01
E 4 02
E 4 03
E 4 AA
E 5 11
E 5 80
E 5 00
E 5 34

//--- compile.f
logic/cpu_pkg.sv
logic/controller.sv
logic/program_counter.sv
logic/register_file.sv
logic/operand_mux.sv
logic/alu.sv
logic/data_memory.sv
logic/cpu.sv
tb/cpu_assert.sv
tb/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - logic/cpu_pkg.sv
  - logic/controller.sv
  - logic/program_counter.sv
  - logic/register_file.sv
  - logic/operand_mux.sv
  - logic/alu.sv
  - logic/data_memory.sv
  - logic/cpu.sv
  - target: test
    files:
      - tb/cpu_assert.sv
      - tb/cpu_tb.sv

//--- tb/cpu_tb.sv
// Testbench for the CPU with ROM and UART models, vector-driven program and byte checks
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int ram_depth = 256;

    logic   system_clk;
    logic   rst_n;
    instr_t rom_data;
    addr_t  pc;
    byte_t  uart_out_data;
    logic   uart_out_strobe;
    logic   uart_out_ready;
    byte_t  uart_in_data;
    logic   uart_in_valid;
    logic   uart_in_ack;

    instr_t rom [65536];                       // Program ROM outside the CPU
    byte_t  in_q [$];                          // UART bytes still to deliver
    int     exp_test [$];                      // Test number of each expected byte
    byte_t  exp_byte [$];
    logic   loaded;
    logic   ack_seen;                          // Byte taken at the last edge
    int     gap;                               // Idle cycles before the next valid
    int     n_expected;
    int     errors, tests_pass, tests_fail;
    int     cur_test, test_bytes, test_errs;
    byte_t  want;
    logic [31:0] rng_state;

    cpu #(.ram_depth(ram_depth)) dut_i (.*);

    always #10 system_clk = ~system_clk;       // 20 ns period

    // 32-bit xorshift generator
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Fill ROM with no-op words, then load program, input and expected records
    task automatic read_vectors();
        int    fd;
        string line;
        int    a, op, t, s_a, s_b, cnd, dir, sf, opnd;
        instr_t w;
        for (int i = 0; i < 65536; i++) begin
            w = '0;
            w.targ = tdev_none;
            w.operand = addr_t'(i);            // Harmless word tagged with its address
            rom[i] = w;
        end
        fd = $fopen("tb/cpu_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/cpu_vectors.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() < 2 || line[0] == "#") continue;
                if (line[0] == "P") begin
                    void'($sscanf(line.substr(1, line.len() - 1),
                                  "%h %h %h %h %h %h %h %h %h",
                                  a, op, t, s_a, s_b, cnd, dir, sf, opnd));
                    w.op = alu_op_e'(op);
                    w.targ = tdev_e'(t);
                    w.a_sel = adev_e'(s_a);
                    w.b_sel = bdev_e'(s_b);
                    w.cond = cond_e'(cnd);
                    w.direct = dir[0];
                    w.set_flags = sf[0];
                    w.spare = '0;
                    w.operand = addr_t'(opnd);
                    rom[a] = w;
                end else if (line[0] == "I") begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%h", a));
                    in_q.push_back(byte_t'(a));
                end else if (line[0] == "E") begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%d %h", t, a));
                    exp_test.push_back(t);
                    exp_byte.push_back(byte_t'(a));
                end
            end
            $fclose(fd);
        end
        n_expected = exp_byte.size();
        if (n_expected == 0) begin
            $display("no expected output bytes were loaded, nothing can be checked");
            errors++;
        end
    endtask

    // ROM, output ready and input byte models driven just after each edge
    always @(posedge system_clk) begin
        #2;
        rom_data <= rom[pc];
        uart_out_ready <= (next_random() % 4) != 0;  // Low about one cycle in four
        if (ack_seen) begin
            void'(in_q.pop_front());
            uart_in_valid <= 1'b0;
            ack_seen = 1'b0;
            gap = next_random() % 6;
        end else if (!uart_in_valid && in_q.size() > 0) begin
            if (gap == 0) begin
                uart_in_valid <= 1'b1;
                uart_in_data <= in_q[0];
            end else begin
                gap--;
            end
        end
    end

    always @(negedge system_clk) begin
        if (rst_n && uart_in_ack) ack_seen = 1'b1;
    end

    // Output byte checker sampled mid-cycle while the strobe is stable
    always @(negedge system_clk) begin
        if (rst_n && uart_out_strobe) begin
            assert (exp_byte.size() > 0) else begin
                $display("unexpected UART byte %02h at %0t ns after all tests",
                         uart_out_data, $time);
                errors++;
            end
            if (exp_byte.size() > 0) begin
                cur_test = exp_test.pop_front();
                want = exp_byte.pop_front();
                test_bytes++;
                assert (uart_out_data == want) else begin
                    $display("[FAIL] %0t ns uart_out_data: got %02h expected %02h",
                             $time, uart_out_data, want);
                    errors++;
                    test_errs++;
                end
                if (exp_test.size() == 0 || exp_test[0] != cur_test) begin
                    $display("test %0d finished: %0d bytes, %0d wrong",
                             cur_test, test_bytes, test_errs);
                    if (test_errs == 0) tests_pass++;
                    else tests_fail++;
                    test_bytes = 0;
                    test_errs = 0;
                end
            end
        end
    end

    initial begin
        system_clk = 1'b0;
        rst_n = 1'b0;
        rom_data = '0;
        uart_out_ready = 1'b0;
        uart_in_data = '0;
        uart_in_valid = 1'b0;
        ack_seen = 1'b0;
        gap = 3;
        errors = 0;
        tests_pass = 0;
        tests_fail = 0;
        test_bytes = 0;
        test_errs = 0;
        rng_state = 32'd49876;
        loaded = 1'b0;
        read_vectors();
        loaded = 1'b1;
        repeat (3) @(posedge system_clk);
        #2 rst_n = 1'b1;
        while (exp_byte.size() > 0) begin
            @(posedge system_clk);
        end
        repeat (20) @(posedge system_clk);  // Catch stray output after the last test
        $display("tests passed: %0d, failed: %0d, errors: %0d",
                 tests_pass, tests_fail, errors);
        if (errors == 0 && tests_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the number of expected bytes
    initial begin
        wait (loaded);
        repeat (200 * n_expected + 1000) @(posedge system_clk);
        $display("timeout: test %0d never finished, %0d output bytes still missing",
                 exp_test.size() > 0 ? exp_test[0] : -1, exp_byte.size());
        $display("Something failed");
        $finish;
    end

endmodule

//--- tb/cpu_assert.sv
// UART strobe protocol assertions bound into the CPU top level
module cpu_assert (
    input logic system_clk,
    input logic rst_n,
    input logic uart_out_strobe,
    input logic uart_out_ready,
    input logic uart_in_ack,
    input logic uart_in_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Write only into a ready device
    out_needs_ready: assert property (@(posedge system_clk) disable iff (!rst_n)
        uart_out_strobe |-> uart_out_ready) else $error("write strobe while not ready");

    in_needs_valid: assert property (@(posedge system_clk) disable iff (!rst_n)
        uart_in_ack |-> uart_in_valid) else $error("ack while no input byte");

    // Pulses, never levels
    out_one_cycle: assert property (@(posedge system_clk) disable iff (!rst_n)
        uart_out_strobe |=> !uart_out_strobe) else $error("write strobe longer than a cycle");

    in_one_cycle: assert property (@(posedge system_clk) disable iff (!rst_n)
        uart_in_ack |=> !uart_in_ack) else $error("ack longer than a cycle");

    quiet_after_reset: assert property (@(posedge system_clk)
        !rst_n ##1 rst_n |-> !uart_out_strobe && !uart_in_ack)
        else $error("strobe in the first cycle after reset");

endmodule

bind cpu cpu_assert u_assert (.*);

//--- logic/cpu.sv
// CPU top level wiring the sequencer to the PC, registers, operand select, ALU and data memory
module cpu #(
    parameter int ram_depth = 256
) (
    input  logic            system_clk,
    input  logic            rst_n,
    input  cpu_pkg::instr_t rom_data,
    output cpu_pkg::addr_t  pc,
    output cpu_pkg::byte_t  uart_out_data,
    output logic            uart_out_strobe,
    input  logic            uart_out_ready,
    input  cpu_pkg::byte_t  uart_in_data,
    input  logic            uart_in_valid,
    output logic            uart_in_ack
);
    import cpu_pkg::*;

    instr_t  ir;
    strobe_t strobes;
    flags_t  flags;
    logic    exec_done;
    byte_t   rd_a, rd_b;
    byte_t   abus, bbus;
    byte_t   result;                           // Shared write bus
    byte_t   ram_data;
    addr_t   mar;

    assign uart_out_data   = result;
    assign uart_out_strobe = strobes.uart_wr;
    assign uart_in_ack     = strobes.uart_ack;

    controller u_ctrl (.system_clk, .rst_n, .rom_data, .flags, .uart_out_ready,
                       .uart_in_valid, .ir, .strobes, .exec_done);

    program_counter u_pc (.system_clk, .rst_n, .exec_done, .pchitmp_we(strobes.pchitmp_we),
                          .pclo_we(strobes.pclo_we), .pc_we(strobes.pc_we), .result, .pc);

    register_file u_regs (.system_clk, .rst_n, .we(strobes.reg_we), .wr_addr(ir.targ[1:0]),
                          .wr_data(result), .rd_a_addr(ir.a_sel[1:0]),
                          .rd_b_addr(ir.b_sel[1:0]), .rd_a, .rd_b);

    operand_mux u_mux (.ir, .rd_a, .rd_b, .mar, .ram_data, .uart_in_data, .abus, .bbus);

    alu u_alu (.system_clk, .rst_n, .op(ir.op), .abus, .bbus,
               .flags_we(strobes.flags_we), .result, .flags);

    data_memory #(.ram_depth(ram_depth)) u_mem (
        .system_clk, .rst_n, .ir, .marlo_we(strobes.marlo_we), .marhi_we(strobes.marhi_we),
        .ram_we(strobes.ram_we), .result, .mar, .ram_data
    );

endmodule

//--- logic/data_memory.sv
// Data memory with the two-byte MAR, direct or register address select and synchronous-write RAM
module data_memory #(
    parameter int ram_depth = 256
) (
    input  logic            system_clk,
    input  logic            rst_n,
    input  cpu_pkg::instr_t ir,
    input  logic            marlo_we,
    input  logic            marhi_we,
    input  logic            ram_we,
    input  cpu_pkg::byte_t  result,
    output cpu_pkg::addr_t  mar,
    output cpu_pkg::byte_t  ram_data
);
    import cpu_pkg::*;

    localparam int aw = $clog2(ram_depth);

    byte_t          mar_lo;
    byte_t          mar_hi;
    addr_t          addr;
    logic [aw-1:0]  ram_addr;
    byte_t          mem [ram_depth];

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            mar_lo <= '0;
            mar_hi <= '0;
        end else begin
            if (marlo_we) mar_lo <= result;
            if (marhi_we) mar_hi <= result;
        end
    end

    assign mar      = {mar_hi, mar_lo};
    assign addr     = ir.direct ? ir.operand : mar;       // Direct vs register addressing
    assign ram_addr = aw'(32'(addr) % ram_depth);         // Wraps past the top

    always_ff @(posedge system_clk) begin
        if (ram_we) mem[ram_addr] <= result;
    end

    assign ram_data = mem[ram_addr];                      // Asynchronous read

endmodule

//--- logic/alu.sv
// 8-bit ALU with the gated status register for the eight flags
module alu (
    input  logic              system_clk,
    input  logic              rst_n,
    input  cpu_pkg::alu_op_e  op,
    input  cpu_pkg::byte_t    abus,
    input  cpu_pkg::byte_t    bbus,
    input  logic              flags_we,
    output cpu_pkg::byte_t    result,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    flags_t      flags_next;
    logic [8:0]  wide;                         // Bit 8 is carry or borrow
    logic [15:0] prod;
    logic        c_next;
    logic        o_next;

    assign prod = abus * bbus;

    always_comb begin
        wide   = '0;
        c_next = 1'b0;
        o_next = 1'b0;
        case (op)
            op_a:      wide[7:0] = abus;
            op_b:      wide[7:0] = bbus;
            op_add, op_adc: begin
                wide   = {1'b0, abus} + {1'b0, bbus} + 9'((op == op_adc) & flags.c);
                c_next = wide[8];
                o_next = (abus[7] == bbus[7]) && (wide[7] != abus[7]);
            end
            op_sub_ab, op_sbb: begin
                wide   = {1'b0, abus} - {1'b0, bbus} - 9'((op == op_sbb) & flags.c);
                c_next = wide[8];                              // Borrow
                o_next = (abus[7] != bbus[7]) && (wide[7] != abus[7]);
            end
            op_sub_ba: begin
                wide   = {1'b0, bbus} - {1'b0, abus};
                c_next = wide[8];
                o_next = (abus[7] != bbus[7]) && (wide[7] != bbus[7]);
            end
            op_and:    wide[7:0] = abus & bbus;
            op_or:     wide[7:0] = abus | bbus;
            op_xor:    wide[7:0] = abus ^ bbus;
            op_nota:   wide[7:0] = ~abus;
            op_mul_lo: wide[7:0] = prod[7:0];
            op_mul_hi: wide[7:0] = prod[15:8];
            op_shl: begin
                wide[7:0] = {abus[6:0], 1'b0};
                c_next    = abus[7];                           // Bit shifted out
            end
            op_shr: begin
                wide[7:0] = {1'b0, abus[7:1]};
                c_next    = abus[0];
            end
            default:   wide = '0;                              // zero and unused codes
        endcase
    end

    assign result = wide[7:0];

    // Compares are unsigned A against B
    assign flags_next = '{c: c_next, z: (result == '0), o: o_next, n: result[7],
                          gt: (abus > bbus), lt: (abus < bbus),
                          eq: (abus == bbus), ne: (abus != bbus)};

    always_ff @(posedge system_clk) begin
        if (!rst_n) flags <= '0;
        else if (flags_we) flags <= flags_next;  // Kept when the instruction is skipped
    end

endmodule

//--- logic/operand_mux.sv
// A and B bus source selection for the ALU operands
module operand_mux (
    input  cpu_pkg::instr_t ir,
    input  cpu_pkg::byte_t  rd_a,
    input  cpu_pkg::byte_t  rd_b,
    input  cpu_pkg::addr_t  mar,
    input  cpu_pkg::byte_t  ram_data,
    input  cpu_pkg::byte_t  uart_in_data,
    output cpu_pkg::byte_t  abus,
    output cpu_pkg::byte_t  bbus
);
    import cpu_pkg::*;

    always_comb begin
        case (ir.a_sel)
            adev_rega, adev_regb,
            adev_regc, adev_regd: abus = rd_a;          // Port A already addressed by a_sel
            adev_marlo:           abus = mar[7:0];
            adev_marhi:           abus = mar[15:8];
            adev_uart:            abus = uart_in_data;
            default:              abus = '0;            // zero source
        endcase
    end

    always_comb begin
        case (ir.b_sel)
            bdev_rega, bdev_regb,
            bdev_regc, bdev_regd: bbus = rd_b;
            bdev_marlo:           bbus = mar[7:0];
            bdev_marhi:           bbus = mar[15:8];
            bdev_immed:           bbus = ir.operand[7:0];  // Immediate in low byte
            default:              bbus = ram_data;      // ram
        endcase
    end

endmodule

//--- logic/register_file.sv
// Four 8-bit general registers, two combinational read ports and one write port
module register_file (
    input  logic           system_clk,
    input  logic           rst_n,
    input  logic           we,
    input  logic [1:0]     wr_addr,
    input  cpu_pkg::byte_t wr_data,
    input  logic [1:0]     rd_a_addr,
    input  logic [1:0]     rd_b_addr,
    output cpu_pkg::byte_t rd_a,
    output cpu_pkg::byte_t rd_b
);
    import cpu_pkg::*;

    byte_t regs [4];                           // rega .. regd

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wr_addr] <= wr_data;          // Written at the EXEC edge
        end
    end

    // Read ports see the old value until the edge
    assign rd_a = regs[rd_a_addr];
    assign rd_b = regs[rd_b_addr];

endmodule

//--- logic/program_counter.sv
// Program counter with increment, low-byte jump and long jump through a high-byte holding register
module program_counter (
    input  logic           system_clk,
    input  logic           rst_n,
    input  logic           exec_done,
    input  logic           pchitmp_we,
    input  logic           pclo_we,
    input  logic           pc_we,
    input  cpu_pkg::byte_t result,
    output cpu_pkg::addr_t pc
);
    import cpu_pkg::*;

    byte_t pchitmp;                            // High byte for the next long jump

    always_ff @(posedge system_clk) begin
        if (pchitmp_we) pchitmp <= result;
    end

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (exec_done) begin
            if (pc_we) begin
                pc <= {pchitmp, result};       // Long jump
            end else if (pclo_we) begin
                pc <= {pc[15:8], result};      // Jump within the page
            end else begin
                pc <= pc + addr_t'(1);
            end
        end
    end

endmodule

//--- logic/controller.sv
// Fetch/execute sequencer with instruction register, condition test and write strobe decode
module controller (
    input  logic             system_clk,
    input  logic             rst_n,
    input  cpu_pkg::instr_t  rom_data,
    input  cpu_pkg::flags_t  flags,
    input  logic             uart_out_ready,
    input  logic             uart_in_valid,
    output cpu_pkg::instr_t  ir,
    output cpu_pkg::strobe_t strobes,
    output logic             exec_done
);
    import cpu_pkg::*;

    typedef enum logic {
        st_fetch,
        st_exec
    } state_e;

    state_e state;
    logic   cond_ok;                           // Instruction's condition holds
    logic   uart_busy;                         // Addressed UART side not ready
    logic   go;                                // Executing this cycle

    always_ff @(posedge system_clk) begin
        if (!rst_n) begin
            state <= st_fetch;
        end else begin
            case (state)
                st_fetch: state <= st_exec;
                st_exec:  if (exec_done) state <= st_fetch;  // Hold while stalled
                default:  state <= st_fetch;
            endcase
        end
    end

    // Instruction register loaded from ROM at pc
    always_ff @(posedge system_clk) begin
        if (state == st_fetch) ir <= rom_data;
    end

    always_comb begin
        case (ir.cond)
            cond_always: cond_ok = 1'b1;
            cond_c:      cond_ok = flags.c;
            cond_z:      cond_ok = flags.z;
            cond_o:      cond_ok = flags.o;
            cond_n:      cond_ok = flags.n;
            cond_gt:     cond_ok = flags.gt;
            cond_lt:     cond_ok = flags.lt;
            cond_eq:     cond_ok = flags.eq;
            cond_ne:     cond_ok = flags.ne;
            cond_di:     cond_ok = uart_in_valid;
            cond_do:     cond_ok = uart_out_ready;
            default:     cond_ok = 1'b0;       // Unused codes never execute
        endcase
    end

    // Stall only when the instruction would really run
    assign uart_busy = (ir.targ == tdev_uart && !uart_out_ready)
                    || (ir.a_sel == adev_uart && !uart_in_valid);

    assign go        = (state == st_exec) && cond_ok && !uart_busy;
    assign exec_done = (state == st_exec) && (!cond_ok || !uart_busy);  // Failed cond skips at once

    always_comb begin
        strobes = '0;
        if (go) begin
            case (ir.targ)
                tdev_rega, tdev_regb,
                tdev_regc, tdev_regd: strobes.reg_we     = 1'b1;
                tdev_marlo:           strobes.marlo_we   = 1'b1;
                tdev_marhi:           strobes.marhi_we   = 1'b1;
                tdev_uart:            strobes.uart_wr    = 1'b1;
                tdev_ram:             strobes.ram_we     = 1'b1;
                tdev_pchitmp:         strobes.pchitmp_we = 1'b1;
                tdev_pclo:            strobes.pclo_we    = 1'b1;
                tdev_pc:              strobes.pc_we      = 1'b1;
                default:              ;        // No write for none
            endcase
            strobes.flags_we = ir.set_flags;
            strobes.uart_ack = (ir.a_sel == adev_uart);  // Byte consumed by this read
        end
    end

endmodule

//--- logic/cpu_pkg.sv
// CPU package with the instruction word, bus device, ALU op, flag and strobe types
package cpu_pkg;

    typedef logic [7:0]  byte_t;               // Data byte on any bus
    typedef logic [15:0] addr_t;               // Program or data address

    typedef enum logic [4:0] {
        op_zero   = 5'd0,  op_a      = 5'd1,  op_b      = 5'd2,  op_add    = 5'd3,
        op_sub_ab = 5'd4,  op_sub_ba = 5'd5,  op_adc    = 5'd6,  op_sbb    = 5'd7,
        op_and    = 5'd8,  op_or     = 5'd9,  op_xor    = 5'd10, op_nota   = 5'd11,
        op_mul_lo = 5'd12, op_mul_hi = 5'd13, op_shl    = 5'd14, op_shr    = 5'd15
    } alu_op_e;

    typedef enum logic [2:0] {                 // A bus sources
        adev_rega, adev_regb, adev_regc, adev_regd,
        adev_marlo, adev_marhi, adev_uart, adev_zero
    } adev_e;

    typedef enum logic [2:0] {                 // B bus sources
        bdev_rega, bdev_regb, bdev_regc, bdev_regd,
        bdev_marlo, bdev_marhi, bdev_immed, bdev_ram
    } bdev_e;

    typedef enum logic [3:0] {
        tdev_rega    = 4'd0, tdev_regb  = 4'd1, tdev_regc = 4'd2,  tdev_regd = 4'd3,
        tdev_marlo   = 4'd4, tdev_marhi = 4'd5, tdev_uart = 4'd6,  tdev_ram  = 4'd7,
        tdev_pchitmp = 4'd8, tdev_pclo  = 4'd9, tdev_pc   = 4'd10, tdev_none = 4'd15
    } tdev_e;

    typedef enum logic [3:0] {
        cond_always = 4'd0, cond_c  = 4'd1, cond_z  = 4'd2, cond_o  = 4'd3,
        cond_n      = 4'd4, cond_gt = 4'd5, cond_lt = 4'd6, cond_eq = 4'd7,
        cond_ne     = 4'd8, cond_di = 4'd9, cond_do = 4'd10  // UART input valid, output ready
    } cond_e;

    typedef struct packed {
        logic c, z, o, n, gt, lt, eq, ne;      // Same order as the status register bits
    } flags_t;

    typedef struct packed {
        alu_op_e op;
        tdev_e   targ;
        adev_e   a_sel;
        bdev_e   b_sel;
        cond_e   cond;
        logic    direct;                       // 1 = operand is the RAM address, 0 = MAR
        logic    set_flags;
        logic [2:0] spare;
        addr_t   operand;                      // Address, or immediate in the low byte
    } instr_t;

    typedef struct packed {
        logic reg_we, marlo_we, marhi_we, ram_we, pchitmp_we;
        logic pclo_we, pc_we, flags_we, uart_wr, uart_ack;
    } strobe_t;

endpackage
